//--- video_pkg.sv
// Shared widths and encodings for the tile-map video subsystem
// Imported by the register block, scroll layer, colour mixer and top level

package video_pkg;

    // Layer pixel is the palette bank bit over a 4-bit colour nibble
    localparam int PXL_W = 5;

    // Palette entry holds 4 bits each of red, green and blue
    localparam int COLOR_W = 12;

    // Nibble value that lets the backdrop show through
    localparam logic [3:0] TRANSPARENT_NIB = 4'hf;

    // Word addresses inside the ppu1 window
    typedef enum logic [4:0] {
        REG_HPOS      = 5'd0,
        REG_VPOS      = 5'd1,
        REG_VRAM_BASE = 5'd2,
        REG_BACKDROP  = 5'd3
    } mmr_reg_e;

    // Scroll fetch sequencer
    typedef enum logic [1:0] {
        SCR_IDLE,
        SCR_VRAM,
        SCR_ROM,
        SCR_DRAW
    } scr_state_e;

endpackage

//--- video_timing.sv
// Video timing generator with pixel and line counters
// Sync and blanking are decoded from the counters, line_start marks each new line

`timescale 1ns/100ps

module video_timing #(
    parameter int H_TOTAL  = 96,
    parameter int H_ACTIVE = 64,
    parameter int HS_START = 72,
    parameter int HS_END   = 80,
    parameter int V_TOTAL  = 24,
    parameter int V_ACTIVE = 16,
    parameter int VS_START = 18,
    parameter int VS_END   = 20
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic [8:0] vrender,
    output logic       line_start,
    output logic       HS,
    output logic       VS,
    output logic       HB,
    output logic       VB
);

    logic h_wrap;
    logic v_last;

    assign h_wrap = hdump == H_TOTAL - 1;
    assign v_last = vdump == V_TOTAL - 1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdump      <= '0;
            vdump      <= '0;
            line_start <= 1'b0;
        end else begin
            // One clk after the pixel that wraps the line
            line_start <= pxl_cen && h_wrap;
            if (pxl_cen) begin
                hdump <= h_wrap ? '0 : hdump + 9'd1;
                if (h_wrap) begin
                    vdump <= v_last ? '0 : vdump + 9'd1;
                end
            end
        end
    end

    // Line being prepared by the scroll layer
    assign vrender = v_last ? '0 : vdump + 9'd1;

    assign HB = hdump >= H_ACTIVE;
    assign VB = vdump >= V_ACTIVE;
    assign HS = hdump >= HS_START && hdump < HS_END;
    assign VS = vdump >= VS_START && vdump < VS_END;

    a_hdump_range: assert property (@(posedge clk) disable iff (!rst_n)
        hdump < H_TOTAL);

endmodule

//--- video_mmr.sv
// CPU register file for the ppu1 window and palette write decode for ppu2
// Writes take the byte lanes given by dsn, reads show up one clk later

`timescale 1ns/100ps

module video_mmr (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ppu_rstn,
    input  logic                          ppu1_cs,
    input  logic                          ppu2_cs,
    input  logic [5:1]                    addr,
    input  logic [1:0]                    dsn,
    input  logic [15:0]                   cpu_dout,
    output logic [15:0]                   mmr_dout,
    output logic [15:0]                   hpos,
    output logic [15:0]                   vpos,
    output logic [15:0]                   vram_base,
    output logic [video_pkg::PXL_W-1:0]   backdrop,
    output logic                          pal_we
);

    import video_pkg::*;

    logic [15:0] rd_word;

    // Upper lane on dsn[1], lower lane on dsn[0]
    function automatic logic [15:0] lane_merge(input logic [15:0] cur,
                                               input logic [15:0] din,
                                               input logic [1:0]  lanes_n);
        logic [15:0] res;
        res = cur;
        if (!lanes_n[1]) begin
            res[15:8] = din[15:8];
        end
        if (!lanes_n[0]) begin
            res[7:0] = din[7:0];
        end
        return res;
    endfunction

    always_comb begin
        case (mmr_reg_e'(addr))
            REG_HPOS:      rd_word = hpos;
            REG_VPOS:      rd_word = vpos;
            REG_VRAM_BASE: rd_word = vram_base;
            REG_BACKDROP:  rd_word = {{(16 - PXL_W){1'b0}}, backdrop};
            default:       rd_word = 16'h0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !ppu_rstn) begin
            hpos      <= '0;
            vpos      <= '0;
            vram_base <= '0;
            backdrop  <= '0;
            mmr_dout  <= '0;
        end else if (ppu1_cs) begin
            mmr_dout <= rd_word;
            case (mmr_reg_e'(addr))
                REG_HPOS:      hpos      <= lane_merge(hpos, cpu_dout, dsn);
                REG_VPOS:      vpos      <= lane_merge(vpos, cpu_dout, dsn);
                REG_VRAM_BASE: vram_base <= lane_merge(vram_base, cpu_dout, dsn);
                REG_BACKDROP: begin
                    if (!dsn[0]) begin
                        backdrop <= cpu_dout[PXL_W-1:0];
                    end
                end
                default: ;
            endcase
        end
    end

    // Palette entry and data come straight from the bus at top level
    assign pal_we = ppu2_cs;

    a_single_window: assert property (@(posedge clk) disable iff (!rst_n)
        !(ppu1_cs && ppu2_cs));

endmodule

//--- video_scroll.sv
// 8x8 tile scroll layer rendering one line ahead into a double line buffer
// Tile words come from VRAM and pixel rows from ROM through cs/ok strobes

`timescale 1ns/100ps

module video_scroll #(
    parameter int H_ACTIVE = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic                          line_start,
    input  logic [8:0]                    vrender,
    input  logic [8:0]                    hdump,
    input  logic [15:0]                   hpos,
    input  logic [15:0]                   vpos,
    input  logic [15:0]                   vram_base,
    input  logic [15:0]                   vram_data,
    input  logic                          vram_ok,
    input  logic [31:0]                   rom_data,
    input  logic                          rom_ok,
    output logic [17:1]                   vram_addr,
    output logic                          vram_cs,
    output logic [19:0]                   rom_addr,
    output logic                          rom_cs,
    output logic [video_pkg::PXL_W-1:0]   scr_pxl
);

    import video_pkg::*;

    localparam int AW = $clog2(H_ACTIVE);
    localparam logic [3:0] LAST_TILE = 4'(H_ACTIVE / 8);
    localparam logic [PXL_W-1:0] CLEAR_PXL = {1'b0, TRANSPARENT_NIB};

    scr_state_e       state;
    logic             front;
    logic             restart;
    logic [3:0]       tile_i;
    logic [2:0]       pix_k;
    logic [8:0]       y_r;
    logic [8:0]       x0_r;
    logic             bank_r;
    logic [14:0]      code_r;
    logic [31:0]      row_r;
    logic [5:0]       map_col;
    logic             busy;
    logic             fetch_done;
    logic             begin_line;
    logic [7:0]       wpos_raw;
    logic [7:0]       fine_x;
    logic [7:0]       wpos;
    logic             wr_ok;
    logic [3:0]       pix_nib;
    logic [PXL_W-1:0] lbuf [2][H_ACTIVE];

    assign busy       = state == SCR_VRAM || state == SCR_ROM;
    assign fetch_done = (state == SCR_VRAM && vram_ok) || (state == SCR_ROM && rom_ok);
    // A line start during a fetch waits for its ok before restarting
    assign begin_line = (line_start && (!busy || fetch_done)) || (restart && fetch_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= SCR_IDLE;
            front   <= 1'b0;
            restart <= 1'b0;
            tile_i  <= '0;
            pix_k   <= '0;
        end else begin
            if (line_start) begin
                front <= ~front;
            end
            if (line_start && busy) begin
                restart <= 1'b1;
            end
            if (begin_line) begin
                restart <= 1'b0;
                state   <= SCR_VRAM;
                tile_i  <= '0;
            end else begin
                case (state)
                    SCR_VRAM: if (vram_ok) state <= SCR_ROM;
                    SCR_ROM: begin
                        if (rom_ok) begin
                            state <= SCR_DRAW;
                            pix_k <= '0;
                        end
                    end
                    SCR_DRAW: begin
                        pix_k <= pix_k + 3'd1;
                        if (pix_k == 3'd7) begin
                            if (tile_i == LAST_TILE) begin
                                state <= SCR_IDLE;
                            end else begin
                                tile_i <= tile_i + 4'd1;
                                state  <= SCR_VRAM;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Line coordinates and fetched words
    always_ff @(posedge clk) begin
        if (begin_line) begin
            y_r  <= vrender + vpos[8:0];
            x0_r <= hpos[8:0];
        end
        if (state == SCR_VRAM && vram_ok) begin
            bank_r <= vram_data[15];
            code_r <= vram_data[14:0];
        end
        if (state == SCR_ROM && rom_ok) begin
            row_r <= rom_data;
        end
    end

    assign map_col   = x0_r[8:3] + {2'b00, tile_i};
    assign vram_addr = {1'b0, vram_base[15:12], y_r[8:3], map_col};
    assign vram_cs   = state == SCR_VRAM;
    assign rom_addr  = {2'b00, code_r, y_r[2:0]};
    assign rom_cs    = state == SCR_ROM;

    // Pixel k sits in nibble k of the ROM row
    assign pix_nib  = row_r[{pix_k, 2'b00} +: 4];
    assign wpos_raw = {1'b0, tile_i, pix_k};
    assign fine_x   = {5'd0, x0_r[2:0]};
    assign wpos     = wpos_raw - fine_x;
    assign wr_ok    = state == SCR_DRAW && !line_start && wpos_raw >= fine_x
                      && wpos < H_ACTIVE;

    // Front half is cleared as it is shown so it comes back empty as the back half
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            lbuf[~front][wpos[AW-1:0]] <= {bank_r, pix_nib};
        end
        if (pxl_cen) begin
            if (hdump < H_ACTIVE) begin
                scr_pxl                     <= lbuf[front][hdump[AW-1:0]];
                lbuf[front][hdump[AW-1:0]] <= CLEAR_PXL;
            end else begin
                scr_pxl <= CLEAR_PXL;
            end
        end
    end

    a_one_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        !(vram_cs && rom_cs));

endmodule

//--- video_colmix.sv
// Colour mixer with the 32-entry palette and backdrop selection
// Colour and the delayed blanking flags leave together, two pixels after hdump

`timescale 1ns/100ps

module video_colmix #(
    parameter int H_ACTIVE = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic                          HB,
    input  logic                          VB,
    input  logic                          gfx_en,
    input  logic [video_pkg::PXL_W-1:0]   scr_pxl,
    input  logic [video_pkg::PXL_W-1:0]   backdrop,
    input  logic                          pal_we,
    input  logic [4:0]                    pal_addr,
    input  logic [video_pkg::COLOR_W-1:0] pal_data,
    output logic                          LHBL_dly,
    output logic                          LVBL_dly,
    output logic [7:0]                    red,
    output logic [7:0]                    green,
    output logic [7:0]                    blue
);

    import video_pkg::*;

    logic [COLOR_W-1:0] pal [32];
    logic [4:0]         pal_idx;
    logic [COLOR_W-1:0] col;
    logic [1:0]         hb_d;
    logic [1:0]         vb_d;
    logic [8:0]         act_cnt;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal[pal_addr] <= pal_data;
        end
    end

    // Backdrop covers transparent pixels and a disabled layer
    assign pal_idx = (!gfx_en || scr_pxl[3:0] == TRANSPARENT_NIB) ? backdrop : scr_pxl;
    assign col     = pal[pal_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hb_d  <= 2'b11;
            vb_d  <= 2'b11;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            hb_d <= {hb_d[0], HB};
            vb_d <= {vb_d[0], VB};
            if (hb_d[0] || vb_d[0]) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= {col[11:8], col[11:8]};
                green <= {col[7:4], col[7:4]};
                blue  <= {col[3:0], col[3:0]};
            end
        end
    end

    assign LHBL_dly = ~hb_d[1];
    assign LVBL_dly = ~vb_d[1];

    // Visible pixel count of the line just ended
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            act_cnt <= '0;
        end else if (pxl_cen) begin
            act_cnt <= LHBL_dly ? act_cnt + 9'd1 : '0;
        end
    end

    a_line_width: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(LHBL_dly) |-> act_cnt == H_ACTIVE);

endmodule

//--- video_top.sv
// Top level of the tile-map video subsystem
// Sets the video timing and connects timing, registers, scroll layer and mixer

`timescale 1ns/100ps

module video_top #(
    parameter int H_TOTAL  = 96,
    parameter int H_ACTIVE = 64,
    parameter int HS_START = 72,
    parameter int HS_END   = 80,
    parameter int V_TOTAL  = 24,
    parameter int V_ACTIVE = 16,
    parameter int VS_START = 18,
    parameter int VS_END   = 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    // CPU
    input  logic        ppu_rstn,
    input  logic        ppu1_cs,
    input  logic        ppu2_cs,
    input  logic [5:1]  addr,
    input  logic [1:0]  dsn,
    input  logic [15:0] cpu_dout,
    output logic [15:0] mmr_dout,
    // VRAM
    output logic [17:1] vram_addr,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output logic        vram_cs,
    // Graphics ROM
    output logic [19:0] rom_addr,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic        rom_cs,
    // Video
    output logic [8:0]  hdump,
    output logic [8:0]  vdump,
    output logic        HS,
    output logic        VS,
    output logic        HB,
    output logic        VB,
    output logic        LHBL_dly,
    output logic        LVBL_dly,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    input  logic        gfx_en
);

    import video_pkg::*;

    logic [8:0]       vrender;
    logic             line_start;
    logic [15:0]      hpos;
    logic [15:0]      vpos;
    logic [15:0]      vram_base;
    logic [PXL_W-1:0] backdrop;
    logic             pal_we;
    logic [PXL_W-1:0] scr_pxl;

    video_timing #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .HS_START ( HS_START ),
        .HS_END   ( HS_END   ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .VS_START ( VS_START ),
        .VS_END   ( VS_END   )
    ) u_timing (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .vrender    ( vrender    ),
        .line_start ( line_start ),
        .HS         ( HS         ),
        .VS         ( VS         ),
        .HB         ( HB         ),
        .VB         ( VB         )
    );

    video_mmr u_mmr (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .ppu_rstn  ( ppu_rstn  ),
        .ppu1_cs   ( ppu1_cs   ),
        .ppu2_cs   ( ppu2_cs   ),
        .addr      ( addr      ),
        .dsn       ( dsn       ),
        .cpu_dout  ( cpu_dout  ),
        .mmr_dout  ( mmr_dout  ),
        .hpos      ( hpos      ),
        .vpos      ( vpos      ),
        .vram_base ( vram_base ),
        .backdrop  ( backdrop  ),
        .pal_we    ( pal_we    )
    );

    video_scroll #(
        .H_ACTIVE ( H_ACTIVE )
    ) u_scroll (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .line_start ( line_start ),
        .vrender    ( vrender    ),
        .hdump      ( hdump      ),
        .hpos       ( hpos       ),
        .vpos       ( vpos       ),
        .vram_base  ( vram_base  ),
        .vram_data  ( vram_data  ),
        .vram_ok    ( vram_ok    ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .vram_addr  ( vram_addr  ),
        .vram_cs    ( vram_cs    ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .scr_pxl    ( scr_pxl    )
    );

    video_colmix #(
        .H_ACTIVE ( H_ACTIVE )
    ) u_colmix (
        .clk      ( clk                    ),
        .rst_n    ( rst_n                  ),
        .pxl_cen  ( pxl_cen                ),
        .HB       ( HB                     ),
        .VB       ( VB                     ),
        .gfx_en   ( gfx_en                 ),
        .scr_pxl  ( scr_pxl                ),
        .backdrop ( backdrop               ),
        .pal_we   ( pal_we                 ),
        .pal_addr ( addr                   ),
        .pal_data ( cpu_dout[COLOR_W-1:0]  ),
        .LHBL_dly ( LHBL_dly               ),
        .LVBL_dly ( LVBL_dly               ),
        .red      ( red                    ),
        .green    ( green                  ),
        .blue     ( blue                   )
    );

endmodule

//--- tb_video.sv
// Testbench for the tile-map video subsystem, driven by commands from video_stim.txt
// Models VRAM and graphics ROM, checks registers, timing and captured pixels

`timescale 1ns/100ps

module tb_video;

    localparam int H_TOTAL      = 96;
    localparam int H_ACTIVE     = 64;
    localparam int HS_START     = 72;
    localparam int HS_END       = 80;
    localparam int V_TOTAL      = 24;
    localparam int V_ACTIVE     = 16;
    localparam int VS_START     = 18;
    localparam int VS_END       = 20;
    localparam int CLK_PERIOD   = 20;
    localparam int CEN_DIV      = 4;
    localparam int RESET_CYCLES = 10;
    localparam longint FRAME_NS = longint'(H_TOTAL) * V_TOTAL * CEN_DIV * CLK_PERIOD;
    localparam string STIM_FILE = "video_stim.txt";

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic        ppu_rstn;
    logic        ppu1_cs;
    logic        ppu2_cs;
    logic [5:1]  addr;
    logic [1:0]  dsn;
    logic [15:0] cpu_dout;
    logic [15:0] mmr_dout;
    logic [17:1] vram_addr;
    logic [15:0] vram_data;
    logic        vram_ok;
    logic        vram_cs;
    logic [19:0] rom_addr;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic        rom_cs;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic        HS;
    logic        VS;
    logic        HB;
    logic        VB;
    logic        LHBL_dly;
    logic        LVBL_dly;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        gfx_en;

    logic [1:0]  cen_div;
    logic        rand_mode;
    logic        stim_loaded;
    int          seed;
    int          vram_wait;
    int          vram_delay;
    int          rom_wait;
    int          rom_delay;
    logic [7:0]  op_q[$];
    logic [31:0] a_q[$];
    logic [31:0] d_q[$];
    logic [31:0] e_q[$];

    video_top #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .HS_START ( HS_START ),
        .HS_END   ( HS_END   ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .VS_START ( VS_START ),
        .VS_END   ( VS_END   )
    ) dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .ppu_rstn  ( ppu_rstn  ),
        .ppu1_cs   ( ppu1_cs   ),
        .ppu2_cs   ( ppu2_cs   ),
        .addr      ( addr      ),
        .dsn       ( dsn       ),
        .cpu_dout  ( cpu_dout  ),
        .mmr_dout  ( mmr_dout  ),
        .vram_addr ( vram_addr ),
        .vram_data ( vram_data ),
        .vram_ok   ( vram_ok   ),
        .vram_cs   ( vram_cs   ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .rom_cs    ( rom_cs    ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .HS        ( HS        ),
        .VS        ( VS        ),
        .HB        ( HB        ),
        .VB        ( VB        ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .gfx_en    ( gfx_en    )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Pixel enable one clk in four
    always @(negedge clk) begin
        cen_div = cen_div + 2'd1;
        pxl_cen = cen_div == 2'd3;
    end

    task automatic stop_with_failure;
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Tile word holds the low 15 address bits, bank taken from address bit 0
    function automatic logic [15:0] vram_word(input logic [17:1] a);
        logic [16:0] wa;
        wa = a;
        return {wa[0], wa[14:0]};
    endfunction

    function automatic logic [31:0] rom_row(input logic [19:0] r);
        if (r % 5 == 0) begin
            return 32'hffff_ffff;
        end
        return {8{r[3:0]}};
    endfunction

    function automatic int pick_ok_delay();
        if (rand_mode) begin
            return $unsigned($random(seed)) % 13;
        end
        return 1;
    endfunction

    // VRAM and ROM answer a held cs after a delay, ok lasts one clk
    always @(negedge clk) begin
        if (vram_ok) begin
            vram_ok    = 1'b0;
            vram_wait  = 0;
            vram_delay = pick_ok_delay();
        end else if (vram_cs) begin
            if (vram_wait >= vram_delay) begin
                vram_data = vram_word(vram_addr);
                vram_ok   = 1'b1;
            end else begin
                vram_wait++;
            end
        end
        if (rom_ok) begin
            rom_ok    = 1'b0;
            rom_wait  = 0;
            rom_delay = pick_ok_delay();
        end else if (rom_cs) begin
            if (rom_wait >= rom_delay) begin
                rom_data = rom_row(rom_addr);
                rom_ok   = 1'b1;
            end else begin
                rom_wait++;
            end
        end
    end

    // Sample point in the middle of the pixel that just started
    task automatic next_pixel;
        do begin
            @(posedge clk);
        end while (pxl_cen !== 1'b1);
        @(negedge clk);
    endtask

    task automatic write_register(input logic [4:0] a, input logic [15:0] d,
                                  input logic [1:0] lanes_n);
        @(negedge clk);
        ppu1_cs  = 1'b1;
        addr     = a;
        dsn      = lanes_n;
        cpu_dout = d;
        @(negedge clk);
        ppu1_cs = 1'b0;
        dsn     = 2'b11;
    endtask

    task automatic write_palette(input logic [4:0] a, input logic [15:0] d);
        @(negedge clk);
        ppu2_cs  = 1'b1;
        addr     = a;
        cpu_dout = d;
        @(negedge clk);
        ppu2_cs = 1'b0;
    endtask

    task automatic read_register(input logic [4:0] a, output logic [15:0] value);
        @(negedge clk);
        ppu1_cs = 1'b1;
        addr    = a;
        dsn     = 2'b11;
        @(negedge clk);
        ppu1_cs = 1'b0;
        value   = mmr_dout;
    endtask

    task automatic pulse_ppu_reset;
        @(negedge clk);
        ppu_rstn = 1'b0;
        @(negedge clk);
        ppu_rstn = 1'b1;
    endtask

    task automatic check_frame_timing;
        int   ln;
        int   px;
        int   act_px;
        int   hs_px;
        int   hs_rise;
        int   vb_lines;
        int   vs_lines;
        int   vs_rise;
        logic hs_prev;
        logic vs_prev;
        do begin
            next_pixel();
        end while (hdump != 0 || vdump != 0);
        hs_prev  = 1'b0;
        vs_prev  = 1'b0;
        vb_lines = 0;
        vs_lines = 0;
        vs_rise  = 0;
        for (ln = 0; ln < V_TOTAL; ln++) begin
            check_val("vdump", vdump, ln);
            act_px  = 0;
            hs_px   = 0;
            hs_rise = 0;
            vb_lines += !VB;
            vs_lines += VS;
            vs_rise  += VS && !vs_prev;
            vs_prev  = VS;
            for (px = 0; px < H_TOTAL; px++) begin
                check_val("hdump", hdump, px);
                act_px  += !HB;
                hs_px   += HS;
                hs_rise += HS && !hs_prev;
                hs_prev = HS;
                next_pixel();
            end
            check_val("HB low pixels", act_px, H_ACTIVE);
            check_val("HS width", hs_px, HS_END - HS_START);
            check_val("HS pulses", hs_rise, 1);
        end
        check_val("VB low lines", vb_lines, V_ACTIVE);
        check_val("VS width", vs_lines, VS_END - VS_START);
        check_val("VS pulses", vs_rise, 1);
    endtask

    // Waits for a whole new frame so register changes have reached every line
    task automatic capture_pixel(input int line_no, input int col_no,
                                 input logic [23:0] exp_rgb);
        int   ln;
        int   cn;
        logic h_prev;
        logic found;
        while (LVBL_dly !== 1'b1) begin
            check_val("vblank red/green/blue", {red, green, blue}, 32'h0);
            next_pixel();
        end
        while (LVBL_dly !== 1'b0) begin
            next_pixel();
        end
        while (LVBL_dly !== 1'b1) begin
            check_val("vblank red/green/blue", {red, green, blue}, 32'h0);
            next_pixel();
        end
        ln     = 0;
        cn     = 0;
        h_prev = 1'b1;
        found  = 1'b0;
        while (!found && LVBL_dly) begin
            if (h_prev && !LHBL_dly) begin
                ln++;
                cn = 0;
            end
            h_prev = LHBL_dly;
            if (LHBL_dly) begin
                if (ln == line_no && cn == col_no) begin
                    check_val("red/green/blue", {red, green, blue}, exp_rgb);
                    found = 1'b1;
                end
                cn++;
            end else begin
                check_val("hblank red/green/blue", {red, green, blue}, 32'h0);
            end
            next_pixel();
        end
        if (!found) begin
            $display("Pixel at line %0d column %0d never appeared in the frame",
                     line_no, col_no);
            stop_with_failure();
        end
    endtask

    // Lines starting with # are comments
    task automatic load_stimulus;
        int                 fd;
        int                 n;
        logic [7:0]         op_ch;
        logic [31:0]        a;
        logic [31:0]        d;
        logic [31:0]        e;
        logic [8*128-1:0]   rest;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", op_ch);
            if (n == 1) begin
                if (op_ch == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    n = $fscanf(fd, " %h %h %h", a, d, e);
                    if (n != 3) begin
                        $display("Stimulus line for opcode %c is missing fields", op_ch);
                        stop_with_failure();
                    end
                    op_q.push_back(op_ch);
                    a_q.push_back(a);
                    d_q.push_back(d);
                    e_q.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_command(input logic [7:0] op, input logic [31:0] a,
                               input logic [31:0] d, input logic [31:0] e);
        logic [15:0] rd;
        case (op)
            "W": write_register(a[4:0], d[15:0], e[1:0]);
            "P": write_palette(a[4:0], d[15:0]);
            "R": begin
                read_register(a[4:0], rd);
                check_val("mmr_dout", rd, e);
            end
            "G": begin
                @(negedge clk);
                gfx_en = d[0];
            end
            "D": begin
                @(posedge clk);
                rand_mode = d[0];
                seed      = 28;
            end
            "X": pulse_ppu_reset();
            "C": capture_pixel(int'(a), int'(d), e[23:0]);
            default: begin
                $display("Unknown stimulus opcode %c", op);
                stop_with_failure();
            end
        endcase
    endtask

    initial begin
        longint limit_ns;
        wait (stim_loaded);
        // Two frames per command, one extra slot for the timing frame
        limit_ns = longint'(RESET_CYCLES) * CLK_PERIOD
                   + longint'(op_q.size() + 1) * 2 * FRAME_NS;
        #(limit_ns);
        $display("Timeout after %0d ns, the stimulus did not complete", limit_ns);
        stop_with_failure();
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        pxl_cen     = 1'b0;
        cen_div     = 2'd0;
        ppu_rstn    = 1'b1;
        ppu1_cs     = 1'b0;
        ppu2_cs     = 1'b0;
        addr        = '0;
        dsn         = 2'b11;
        cpu_dout    = '0;
        vram_data   = '0;
        vram_ok     = 1'b0;
        rom_data    = '0;
        rom_ok      = 1'b0;
        gfx_en      = 1'b1;
        seed        = 28;
        rand_mode   = 1'b0;
        vram_wait   = 0;
        vram_delay  = 1;
        rom_wait    = 0;
        rom_delay   = 1;
        stim_loaded = 1'b0;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        check_val("hdump", hdump, 0);
        check_val("vdump", vdump, 0);
        check_val("HS", HS, 0);
        check_val("VS", VS, 0);
        check_val("line_start", dut.u_timing.line_start, 0);
        check_val("vram_cs", vram_cs, 0);
        check_val("rom_cs", rom_cs, 0);
        rst_n = 1'b1;
        check_frame_timing();
        foreach (op_q[i]) begin
            run_command(op_q[i], a_q[i], d_q[i], e_q[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- video_stim.txt
# Columns: opcode addr data expected, all hex. W uses expected as dsn, R compares mmr_dout
# P palette entry=addr, G gfx_en=data, D random ok delay=data, X ppu_rstn pulse, C line col rgb
P 01 0123 0
P 1b 0abc 0
P 10 00f0 0
P 1a 0f00 0
P 03 0456 0
P 18 000f 0
P 02 0789 0
W 00 1234 0
R 00 0000 1234
W 00 abcd 2
R 00 0000 12cd
W 00 ffee 1
R 00 0000 ffcd
W 00 5555 3
R 00 0000 ffcd
W 01 5a5a 0
R 01 0000 5a5a
W 02 7000 0
R 02 0000 7000
W 03 ffff 0
R 03 0000 001f
X 00 0000 0
R 00 0000 0000
R 01 0000 0000
R 02 0000 0000
R 03 0000 0000
W 03 0010 0
C 01 00 112233
C 03 09 aabbcc
C 02 08 00ff00
C 0a 1c ff0000
G 00 0000 0
C 01 00 00ff00
C 0a 1c 00ff00
G 00 0001 0
W 00 0013 0
W 01 000b 0
C 00 00 445566
C 04 05 00ff00
C 0d 2c 0000ff
C 07 3f 778899
D 00 0001 0
C 00 00 445566
C 04 05 00ff00
C 0d 2c 0000ff
C 07 3f 778899
D 00 0000 0

//--- all.f
video_pkg.sv
video_timing.sv
video_mmr.sv
video_scroll.sv
video_colmix.sv
video_top.sv
tb_video.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_video
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
